// ==== build.f ====
+incdir+include
src/ptw_pkg.sv
src/ptw_fsm.sv
src/ptw_level_counter.sv
src/ptw_walk_regs.sv
src/pte_checker.sv
src/ptw_top.sv
sim/ptw_tb.sv

// ==== include/ptw_params.svh ====
/*
 * Page table walker parameters.
 * Word widths, walk depth limits and the SATP mode codes.
 */
`ifndef PTW_PARAMS_SVH
`define PTW_PARAMS_SVH

`define PTW_XLEN        64   // address and data word
`define PTW_ID_W        8    // request id
`define PTW_VPN_W       9    // one vpn field
`define PTW_PPN_W       44   // physical page number
`define PTW_PAGE_SHIFT  12   // page offset bits
`define PTW_FLAGS_W     8    // pte permission flags

`define PTW_MAX_LEVELS  5    // sv57 walk depth
`define PTW_LEVEL_W     3    // holds levels 0 to 4

// satp mode field, top nibble of the word
`define PTW_MODE_W      4
`define PTW_MODE_SV39   4'd8
`define PTW_MODE_SV48   4'd9
`define PTW_MODE_SV57   4'd10

`endif

// ==== run_sim.sh ====
#!/bin/sh
# build the page table walker testbench with Verilator, run it, grade from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module ptw_tb -f build.f -o ptw_sim > build.log 2>&1 \
    || { echo "verilator build failed, see build.log"; exit 1; }

./obj_dir/ptw_sim > sim.log 2>&1

grep -q "^Simulation passed$" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL, see sim.log"; exit 1; }

// ==== sim/ptw_tb.sv ====
/*
 * Page table walker testbench.
 * Builds random page tables and requests from an LFSR, serves reads from a
 * sparse memory model with stalls and delays, and checks each response
 * against a reference walk.
 */
`timescale 1ns/1ps
`default_nettype none

`include "ptw_params.svh"

module ptw_tb;
    import ptw_pkg::*;

    localparam int NUM_REQ     = 200;
    localparam int WATCHDOG_NS = NUM_REQ * 400;

    logic     clk;
    logic     rst;
    xlt_req_t req;
    logic     req_ready;
    xlt_rsp_t rsp;
    mem_req_t mem_req;
    logic     mem_ready;
    mem_rsp_t mem_rsp;

    logic [15:0]          lfsr = 16'd36;
    logic [`PTW_XLEN-1:0] mem [logic [`PTW_XLEN-1:0]]; // sparse page table memory
    logic [`PTW_XLEN-1:0] exp_addrs[$];               // reads the reference walk makes
    int next_table = 'h100;                           // table ppn allocator below the roots
    int walk_reads = 0;
    int rsp_cycles = 0;
    int faults     = 0;
    int checks     = 0;
    int errors     = 0;

    ptw_top dut (
        .clk(clk), .rst(rst), .req(req), .req_ready(req_ready), .rsp(rsp),
        .mem_req(mem_req), .mem_ready(mem_ready), .mem_rsp(mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // 16-bit galois lfsr stepped once per bit
    function automatic logic [63:0] next_bits(input int n);
        logic [63:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[62:0], lfsr[0]};
            lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
        end
        return bits;
    endfunction

    function automatic logic [`PTW_PPN_W-1:0] low_mask(input int lvl);
        return (44'd1 << (`PTW_VPN_W * lvl)) - 44'd1; // ppn fields below lvl
    endfunction

    function automatic int start_level(input logic [`PTW_MODE_W-1:0] mode);
        case (mode)
            `PTW_MODE_SV39: return 2;
            `PTW_MODE_SV48: return 3;
            `PTW_MODE_SV57: return 4;
            default:        return -1; // no walk at all
        endcase
    endfunction

    function automatic logic [63:0] pte_addr_of(input logic [43:0] ppn, input logic [8:0] idx);
        return (64'(ppn) << `PTW_PAGE_SHIFT) + 64'(idx) * 64'd8; // table base plus 8 bytes per entry
    endfunction

    function automatic logic [63:0] mem_read(input logic [63:0] addr);
        return mem.exists(addr) ? mem[addr] : 64'd0; // unmapped reads as V clear
    endfunction

    function automatic logic [63:0] new_entry(input int lvl);
        logic [3:0]  kind;
        logic [2:0]  xwr;
        logic [43:0] ppn;
        kind = 4'(next_bits(4));
        if (kind == 4'd0)
            return {10'b0, 44'(next_bits(20)), 2'b00, 7'(next_bits(7)), 1'b0}; // V clear
        if (lvl == 0 && kind == 4'd1)
            return {10'b0, 44'(next_bits(16)), 2'b00, 8'h01}; // pointer at the last level
        if (lvl > 0 && kind < 4'd12) begin
            next_table++;
            return {10'b0, 44'(next_table), 2'(next_bits(2)), 8'h01};
        end
        xwr = 3'(next_bits(3));
        if (!xwr[0] && !xwr[2]) xwr[0] = 1'b1; // leaf needs R or X
        ppn = 44'(next_bits(44));
        if (lvl > 0 && next_bits(2) != 0) ppn = ppn & ~low_mask(lvl); // aligned superpage
        return {10'b0, ppn, 2'(next_bits(2)), 4'(next_bits(4)), xwr, 1'b1};
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // creates missing entries along the path of one request
    task automatic build_path(input xlt_req_t r);
        int          lvl;
        logic [43:0] ppn;
        logic [63:0] addr;
        logic [63:0] pte;
        lvl = start_level(r.satp[63 -: 4]);
        ppn = r.satp[43:0];
        while (lvl >= 0) begin
            addr = pte_addr_of(ppn, r.vadd[12 + 9 * lvl +: 9]);
            if (!mem.exists(addr)) mem[addr] = new_entry(lvl);
            pte = mem[addr];
            if (pte[0] && !pte[1] && !pte[3]) begin
                ppn = pte[53:10];
                lvl--;
            end else begin
                lvl = -1;
            end
        end
    endtask

    task automatic make_request(input int k, output xlt_req_t r);
        logic [3:0]  pick;
        logic [3:0]  mode;
        logic [63:0] vadd;
        pick = 4'(next_bits(4));
        if (pick == 4'd0) begin
            mode = 4'(next_bits(4));
            if (start_level(mode) >= 0) mode = 4'd0; // keep it an invalid mode
        end else begin
            mode = 4'd8 + 4'(pick % 3);
        end
        vadd = '0;
        for (int i = 0; i < `PTW_MAX_LEVELS; i++)
            vadd[12 + 9 * i +: 9] = 9'(next_bits(2)); // small index range hits the tables
        vadd[11:0] = 12'(next_bits(12));
        r.id   = 8'(k % 255 + 1);
        r.vadd = vadd;
        r.satp = {mode, 16'h0000, 44'h1000 * 44'(mode[1:0] + 2'd1)}; // one root per mode
        build_path(r);
    endtask

    task automatic model_walk(input xlt_req_t r, output logic [7:0] perm,
                              output logic [63:0] padd, output int reads);
        int          lvl;
        logic [43:0] ppn;
        logic [43:0] leaf_ppn;
        logic [43:0] mask;
        logic [63:0] addr;
        logic [63:0] pte;
        perm  = '0;
        padd  = '0;
        reads = 0;
        lvl   = start_level(r.satp[63 -: 4]);
        ppn   = r.satp[43:0];
        while (lvl >= 0) begin
            addr = pte_addr_of(ppn, r.vadd[12 + 9 * lvl +: 9]);
            exp_addrs.push_back(addr);
            reads++;
            pte  = mem_read(addr);
            mask = low_mask(lvl);
            if (!pte[0]) begin
                lvl = -1; // invalid entry
            end else if (pte[1] || pte[3]) begin
                leaf_ppn = pte[53:10];
                if ((leaf_ppn & mask) == '0) begin
                    leaf_ppn = leaf_ppn | (r.vadd[12 +: 44] & mask); // superpage offset from vpn
                    perm     = pte[7:0];
                    padd     = {8'b0, leaf_ppn, 12'b0};
                end
                lvl = -1;
            end else if (lvl == 0) begin
                lvl = -1; // pointer with no level left
            end else begin
                ppn = pte[53:10];
                lvl--;
            end
        end
    endtask

    task automatic accept_read(input logic [63:0] addr, output logic [63:0] data);
        walk_reads++;
        if (exp_addrs.size() == 0) begin
            errors++;
            $display("error at %0t: read of address %h beyond the reference walk", $time, addr);
        end else begin
            check_value(addr, exp_addrs.pop_front(), "PTE read address");
        end
        data = mem_read(addr);
    endtask

    task automatic run_request(input int k);
        xlt_req_t    r;
        logic [7:0]  exp_perm;
        logic [63:0] exp_padd;
        int          exp_reads;
        make_request(k, r);
        model_walk(r, exp_perm, exp_padd, exp_reads);
        if (exp_perm == '0) faults++;
        walk_reads = 0;
        check_value(64'(req_ready), 64'd1, "req_ready while idle");
        req = r;
        @(negedge clk);
        while (rsp.id == '0) begin
            check_value(64'(req_ready), 64'd0, "req_ready during walk");
            @(negedge clk);
        end
        check_value(64'(rsp.id), 64'(r.id), "rsp.id");
        check_value(64'(rsp.perm), 64'(exp_perm), "rsp.perm");
        check_value(rsp.padd, exp_padd, "rsp.padd");
        check_value(64'(req_ready), 64'd0, "req_ready in done");
        check_value(64'(walk_reads), 64'(exp_reads), "reads per walk");
        req = '0;
        @(negedge clk);
        check_value(64'(|rsp), 64'd0, "rsp cleared after one cycle");
        check_value(64'(req_ready), 64'd1, "req_ready back after done");
        exp_addrs.delete();
        repeat (int'(next_bits(1))) @(negedge clk); // idle gap
    endtask

    // memory port that draws random bits only while a read is in progress
    initial begin : memory_model
        logic        stalled;
        logic        pending;
        int          wait_cycles;
        logic [63:0] held_addr;
        logic [63:0] rdata;
        mem_ready   = 1'b0;
        mem_rsp     = '0;
        stalled     = 1'b0;
        pending     = 1'b0;
        wait_cycles = 0;
        held_addr   = '0;
        rdata       = '0;
        forever begin
            @(negedge clk);
            mem_rsp.valid = 1'b0;
            mem_ready     = 1'b0;
            if (pending) begin
                if (wait_cycles == 0) begin
                    mem_rsp.valid = 1'b1;
                    mem_rsp.data  = rdata;
                    pending       = 1'b0;
                end else begin
                    wait_cycles--;
                end
            end
            if (mem_req.valid) begin
                if (stalled) check_value(mem_req.addr, held_addr, "mem_req.addr during stall");
                mem_ready = next_bits(2) != 0; // stall one cycle in four
                if (mem_ready) begin
                    stalled = 1'b0;
                    accept_read(mem_req.addr, rdata);
                    wait_cycles = int'(next_bits(2));
                    if (wait_cycles == 0) begin
                        mem_rsp.valid = 1'b1; // answer in the handoff cycle
                        mem_rsp.data  = rdata;
                    end else begin
                        pending = 1'b1;
                        wait_cycles--;
                    end
                end else begin
                    stalled   = 1'b1;
                    held_addr = mem_req.addr;
                end
            end
        end
    end

    initial begin : rsp_monitor
        forever begin
            @(negedge clk);
            if (!rst && rsp != '0) rsp_cycles++;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog: walker stopped responding");
        $display("Simulation failed");
        $finish;
    end

    initial begin : stimulus
        rst = 1'b1;
        req = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value(64'(|rsp), 64'd0, "rsp after reset");
        check_value(64'(mem_req.valid), 64'd0, "mem_req.valid after reset");
        check_value(64'(req_ready), 64'd1, "req_ready after reset");
        for (int k = 0; k < NUM_REQ; k++) run_request(k);
        check_value(64'(rsp_cycles), 64'(NUM_REQ), "cycles with a response");
        $display("ptw_tb: %0d requests, %0d faults, %0d checks, %0d errors",
                 NUM_REQ, faults, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/pte_checker.sv ====
/*
 * Page table entry checker.
 * Decodes a PTE into leaf or pointer, detects page faults and
 * merges the VPN into the low PPN fields of a superpage.
 */
`timescale 1ns/1ps
`default_nettype none

`include "ptw_params.svh"

module pte_checker (
    input  ptw_pkg::pte_u                         pte,
    input  logic [`PTW_MAX_LEVELS*`PTW_VPN_W-1:0] vpn,
    input  logic [`PTW_LEVEL_W-1:0]               level,
    input  logic                                  last_level,
    output logic                                  leaf,
    output logic                                  fault,
    output logic [`PTW_PPN_W-1:0]                 next_ppn,
    output logic [`PTW_PPN_W-1:0]                 leaf_ppn,
    output ptw_pkg::pte_flags_t                   perm
);
    localparam int VPN_W      = `PTW_VPN_W;
    localparam int LOW_FIELDS = `PTW_MAX_LEVELS - 1; // fields a superpage can cover

    logic                  misaligned;
    logic [`PTW_PPN_W-1:0] merged_ppn;

    always_comb begin
        misaligned = 1'b0;
        merged_ppn = pte.fields.ppn;
        for (int i = 0; i < LOW_FIELDS; i++) begin
            if (i < int'(level)) begin
                // fields below the leaf level must be zero
                if (pte.fields.ppn[i*VPN_W +: VPN_W] != '0) misaligned = 1'b1;
                merged_ppn[i*VPN_W +: VPN_W] = vpn[i*VPN_W +: VPN_W];
            end
        end
    end

    assign leaf     = pte.fields.flags.r || pte.fields.flags.x;
    assign fault    = !pte.fields.flags.v
                   || (!leaf && last_level)   // pointer with no level left
                   || (leaf && misaligned);
    assign next_ppn = pte.fields.ppn;
    assign leaf_ppn = merged_ppn;
    assign perm     = pte.fields.flags;

endmodule

`default_nettype wire

// ==== src/ptw_fsm.sv ====
/*
 * Page table walk state machine.
 * Captures a request, then loops setup, read and check once per
 * level until a leaf or a fault, and signals the response in done.
 */
`timescale 1ns/1ps
`default_nettype none

module ptw_fsm (
    input  logic clk,
    input  logic rst,
    input  logic req_valid,
    input  logic mode_ok,
    input  logic mem_ready,
    input  logic mem_rsp_valid,
    input  logic fault,
    input  logic leaf,
    output logic req_ready,
    output logic mem_valid,
    output logic load,
    output logic step,
    output logic pte_latch,
    output logic resp_valid,
    output logic resp_fault
);
    import ptw_pkg::*;

    walk_state_e state;
    walk_state_e state_next;
    logic        fault_q; // response carries a page fault

    always_comb begin
        state_next = state;
        case (state)
            walk_idle: begin
                if (req_valid) state_next = mode_ok ? walk_setup : walk_done;
            end
            walk_setup: state_next = walk_read;
            walk_read: begin
                if (pte_latch) state_next = walk_check;
            end
            walk_check: state_next = (fault || leaf) ? walk_done : walk_setup;
            walk_done:  state_next = walk_idle;
            default:    state_next = walk_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= walk_idle;
            mem_valid <= 1'b0;
            fault_q   <= 1'b0;
        end else begin
            state <= state_next;
            if (state == walk_setup) mem_valid <= 1'b1;             // address formed
            else if (mem_valid && mem_ready) mem_valid <= 1'b0;     // handoff
            if (load) fault_q <= !mode_ok;
            else if (state == walk_check) fault_q <= fault;
        end
    end

    assign req_ready  = state == walk_idle;
    assign load       = req_ready && req_valid;
    // a response only counts once the read has been handed off
    assign pte_latch  = (state == walk_read) && mem_rsp_valid && (!mem_valid || mem_ready);
    assign step       = (state == walk_check) && !fault && !leaf; // pointer goes one level deeper
    assign resp_valid = state == walk_done;
    assign resp_fault = fault_q;

    // the read request lives only inside the read phase
    mem_valid_in_read: assert property (
        @(posedge clk) disable iff (rst) mem_valid |-> state == walk_read
    ) else $error("mem_valid raised outside read");

    resp_single_cycle: assert property (
        @(posedge clk) disable iff (rst) resp_valid |=> !resp_valid
    ) else $error("response held longer than one cycle");

endmodule

`default_nettype wire

// ==== src/ptw_level_counter.sv ====
/*
 * Walk level counter.
 * Loads the top level from the SATP mode, steps down once
 * per pointer entry and flags the last level.
 */
`timescale 1ns/1ps
`default_nettype none

`include "ptw_params.svh"

module ptw_level_counter (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load,
    input  logic                    step,
    input  logic [`PTW_MODE_W-1:0]  mode,
    output logic [`PTW_LEVEL_W-1:0] level,
    output logic                    last_level,
    output logic                    mode_ok
);
    logic [`PTW_LEVEL_W-1:0] start_level;

    always_comb begin
        mode_ok = 1'b1;
        case (mode)
            `PTW_MODE_SV39: start_level = `PTW_LEVEL_W'(`PTW_MAX_LEVELS - 3);
            `PTW_MODE_SV48: start_level = `PTW_LEVEL_W'(`PTW_MAX_LEVELS - 2);
            `PTW_MODE_SV57: start_level = `PTW_LEVEL_W'(`PTW_MAX_LEVELS - 1);
            default: begin
                start_level = '0; // bare or reserved mode
                mode_ok     = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) level <= '0;
        else if (load) level <= start_level;
        else if (step) level <= level - 1'b1;
    end

    assign last_level = level == '0;

    // the checker must fault a pointer entry before it reaches this
    no_step_below_zero: assert property (
        @(posedge clk) disable iff (rst) step |-> level != '0
    ) else $error("level counter stepped below level 0");

endmodule

`default_nettype wire

// ==== src/ptw_pkg.sv ====
/*
 * Page table walker types.
 * Request and response words, the memory read port
 * and the two decodings of a page table entry.
 */
`default_nettype none

`include "ptw_params.svh"

package ptw_pkg;

    typedef struct packed {
        logic [`PTW_ID_W-1:0] id;   // zero means no request
        logic [`PTW_XLEN-1:0] vadd;
        logic [`PTW_XLEN-1:0] satp;
    } xlt_req_t;

    typedef struct packed {
        logic [`PTW_ID_W-1:0]    id;
        logic [`PTW_FLAGS_W-1:0] perm; // zero on a page fault
        logic [`PTW_XLEN-1:0]    padd;
    } xlt_rsp_t;

    typedef struct packed {
        logic                 valid;
        logic [`PTW_XLEN-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic                 valid;
        logic [`PTW_XLEN-1:0] data;
    } mem_rsp_t;

    typedef struct packed {
        logic d;
        logic a;
        logic g;
        logic u;
        logic x;
        logic w;
        logic r;
        logic v;
    } pte_flags_t;

    // raw memory word or the decoded entry
    typedef union packed {
        logic [`PTW_XLEN-1:0] raw;
        struct packed {
            logic [9:0]            reserved;
            logic [`PTW_PPN_W-1:0] ppn;
            logic [1:0]            rsw;
            pte_flags_t            flags;
        } fields;
    } pte_u;

    typedef enum logic [2:0] {
        walk_idle,
        walk_setup,
        walk_read,
        walk_check,
        walk_done
    } walk_state_e;

endpackage

`default_nettype wire

// ==== src/ptw_top.sv ====
/*
 * Page table walker top level.
 * Connects the state machine, level counter, walk registers
 * and PTE checker, and forms the translation response.
 */
`timescale 1ns/1ps
`default_nettype none

`include "ptw_params.svh"

module ptw_top (
    input  logic              clk,
    input  logic              rst,
    input  ptw_pkg::xlt_req_t req,
    output logic              req_ready,
    output ptw_pkg::xlt_rsp_t rsp,
    output ptw_pkg::mem_req_t mem_req,
    input  logic              mem_ready,
    input  ptw_pkg::mem_rsp_t mem_rsp
);
    import ptw_pkg::*;

    localparam int PADD_PAD = `PTW_XLEN - `PTW_PPN_W - `PTW_PAGE_SHIFT;

    logic                                  req_valid;
    logic                                  mode_ok;
    logic                                  fault;
    logic                                  leaf;
    logic                                  load;
    logic                                  step;
    logic                                  pte_latch;
    logic                                  resp_valid;
    logic                                  resp_fault;
    logic                                  rsp_ok;
    logic                                  last_level;
    logic [`PTW_LEVEL_W-1:0]               level;
    logic [`PTW_MAX_LEVELS*`PTW_VPN_W-1:0] vpn;
    logic [`PTW_ID_W-1:0]                  id;
    logic [`PTW_PPN_W-1:0]                 next_ppn;
    logic [`PTW_PPN_W-1:0]                 leaf_ppn;
    logic [`PTW_XLEN-1:0]                  pte_addr;
    pte_u                                  pte;
    pte_flags_t                            perm;

    assign req_valid = |req.id;

    ptw_fsm u_fsm (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .mode_ok(mode_ok),
        .mem_ready(mem_ready), .mem_rsp_valid(mem_rsp.valid),
        .fault(fault), .leaf(leaf),
        .req_ready(req_ready), .mem_valid(mem_req.valid),
        .load(load), .step(step), .pte_latch(pte_latch),
        .resp_valid(resp_valid), .resp_fault(resp_fault)
    );

    ptw_level_counter u_level (
        .clk(clk), .rst(rst), .load(load), .step(step),
        .mode(req.satp[`PTW_XLEN-1 -: `PTW_MODE_W]),
        .level(level), .last_level(last_level), .mode_ok(mode_ok)
    );

    ptw_walk_regs u_regs (
        .clk(clk), .rst(rst), .load(load), .step(step), .pte_latch(pte_latch),
        .req(req), .next_ppn(next_ppn), .mem_rsp(mem_rsp), .level(level),
        .pte(pte), .vpn(vpn), .id(id), .ppn(), .pte_addr(pte_addr)
    );

    pte_checker u_check (
        .pte(pte), .vpn(vpn), .level(level), .last_level(last_level),
        .leaf(leaf), .fault(fault), .next_ppn(next_ppn),
        .leaf_ppn(leaf_ppn), .perm(perm)
    );

    assign mem_req.addr = pte_addr;

    assign rsp_ok   = resp_valid && !resp_fault; // fault answers with perm 0
    assign rsp.id   = resp_valid ? id : '0;
    assign rsp.perm = rsp_ok ? perm : '0;
    assign rsp.padd = rsp_ok ? {{PADD_PAD{1'b0}}, leaf_ppn, {`PTW_PAGE_SHIFT{1'b0}}} : '0;

endmodule

`default_nettype wire

// ==== src/ptw_walk_regs.sv ====
/*
 * Walk registers.
 * Hold the request id, the VPN fields and the current table PPN,
 * latch the returned PTE and form the next PTE address.
 */
`timescale 1ns/1ps
`default_nettype none

`include "ptw_params.svh"

module ptw_walk_regs (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  load,
    input  logic                                  step,
    input  logic                                  pte_latch,
    input  ptw_pkg::xlt_req_t                     req,
    input  logic [`PTW_PPN_W-1:0]                 next_ppn,
    input  ptw_pkg::mem_rsp_t                     mem_rsp,
    input  logic [`PTW_LEVEL_W-1:0]               level,
    output ptw_pkg::pte_u                         pte,
    output logic [`PTW_MAX_LEVELS*`PTW_VPN_W-1:0] vpn,
    output logic [`PTW_ID_W-1:0]                  id,
    output logic [`PTW_PPN_W-1:0]                 ppn,
    output logic [`PTW_XLEN-1:0]                  pte_addr
);
    localparam int VPN_W     = `PTW_VPN_W;
    localparam int VPN_ALL_W = `PTW_MAX_LEVELS * `PTW_VPN_W;
    localparam int ADDR_PAD  = `PTW_XLEN - `PTW_PPN_W - VPN_W - 3;

    logic [VPN_W-1:0] vpn_field; // index into the current table

    always_ff @(posedge clk) begin
        if (rst) id <= '0;
        else if (load) id <= req.id;
    end

    always_ff @(posedge clk) begin
        if (load) begin
            vpn <= req.vadd[`PTW_PAGE_SHIFT +: VPN_ALL_W];
            ppn <= req.satp[`PTW_PPN_W-1:0]; // root table
        end else if (step) begin
            ppn <= next_ppn; // next level table
        end
        if (pte_latch) pte.raw <= mem_rsp.data;
    end

    assign vpn_field = vpn[int'(level)*VPN_W +: VPN_W];

    // 8-byte entries, so the index is scaled by 3 zero bits
    assign pte_addr = {{ADDR_PAD{1'b0}}, ppn, vpn_field, 3'b000};

endmodule

`default_nettype wire
